// ==== sim.f ====
hdl/core_pkg.sv
hdl/instr_store.sv
hdl/control_unit.sv
hdl/decoder.sv
hdl/register_file.sv
hdl/exec_unit.sv
hdl/core_top.sv
dv/clock_gen.sv
dv/core_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --Mdir obj_dir
TOP      = core_tb
RTL_TOP  = core_top
FILELIST = sim.f

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)

# Exit status follows the pass line in the simulator output
run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	$(SIM) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== dv/core_tb.sv ====
// Table-driven testbench for the multichannel processing core
module core_tb import core_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_DEPTH      = 64;
    localparam int PC_BITS         = $clog2(PROG_DEPTH);
    localparam int CLK_PERIOD      = 10;
    localparam int N_ROWS          = 11;
    localparam int WATCHDOG_CYCLES = N_ROWS * 200 + 1000;
    localparam int DONE_LIMIT      = 150;
    localparam logic [31:0] SEED      = 32'hacadd3ab;
    localparam logic [31:0] R2_MARK   = 32'h2200_0000;
    localparam logic [31:0] R3_MARK   = 32'h3300_0000;
    localparam logic [31:0] BUSY_MARK = 32'h5a5a_0000;
    localparam logic [31:0] BLOCKED   = 32'hdead_beef;

    typedef struct packed {
        opcode_e     op;
        logic [31:0] base;
        logic [31:0] b;
        logic [1:0]  nch;
    } row_t;

    logic                  clock;
    logic                  rst_n;
    logic                  prog_we;
    logic [PC_BITS-1:0]    prog_addr;
    logic [31:0]           prog_data;
    logic                  reg_we;
    logic [ADDR_BITS-1:0]  reg_addr;
    logic [31:0]           reg_wdata;
    logic [ADDR_BITS-1:0]  reg_raddr;
    logic [31:0]           reg_rdata;
    logic                  run;
    logic [CH_BITS-1:0]    n_channels;
    logic                  busy;
    logic                  done;

    row_t  rows [N_ROWS];
    string names [N_ROWS];
    int    errors       = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    done_count   = 0;

    clock_gen clk_i (.clock, .rst_n);

    core_top #(.PROG_DEPTH(PROG_DEPTH)) dut_i (
        .clock, .rst_n, .prog_we, .prog_addr, .prog_data,
        .reg_we, .reg_addr, .reg_wdata, .reg_raddr, .reg_rdata,
        .run, .n_channels, .busy, .done
    );

    // Every done pulse is seen once at the falling edge
    always @(negedge clock) begin
        if (done) begin
            done_count++;
        end
    end

    //////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////

    function automatic logic [31:0] encode(opcode_e op, logic [5:0] dest,
                                           logic [5:0] src_a, logic [5:0] src_b);
        return {op, dest, src_a, src_b, 9'd0};
    endfunction

    function automatic logic [31:0] expected_result(opcode_e op, logic [31:0] a,
                                                    logic [31:0] b);
        logic [63:0] product;
        product = 64'(a) * 64'(b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a + ~b + 32'd1;
            op_mul:  return product[31:0];
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_shl:  return a << b[4:0];
            default: return 32'd0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("error at %0d ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("%-12s ok", name);
        end else begin
            tests_failed++;
            $display("%-12s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    //////////////////////////////////////////////////
    // Host port drivers
    //////////////////////////////////////////////////

    task automatic write_prog_word(input int addr, input logic [31:0] data);
        prog_we   = 1'b1;
        prog_addr = PC_BITS'(addr);
        prog_data = data;
        @(posedge clock);
        #1;
        prog_we = 1'b0;
    endtask

    // ldc r2, pad, op r3 = r1 op r2, pad, stop
    task automatic load_program(input opcode_e op, input logic [31:0] b);
        write_prog_word(0, encode(op_ldc, 6'd2, 6'd0, 6'd0));
        write_prog_word(1, b);
        for (int k = 2; k <= 4; k++) begin
            write_prog_word(k, encode(op_nop, 6'd0, 6'd0, 6'd0));
        end
        write_prog_word(5, encode(op, 6'd3, 6'd1, 6'd2));
        for (int k = 6; k <= 8; k++) begin
            write_prog_word(k, encode(op_nop, 6'd0, 6'd0, 6'd0));
        end
        write_prog_word(9, encode(op_stop, 6'd0, 6'd0, 6'd0));
    endtask

    task automatic write_reg(input logic [1:0] ch, input logic [5:0] idx,
                             input logic [31:0] data);
        reg_we    = 1'b1;
        reg_addr  = {ch, idx};
        reg_wdata = data;
        @(posedge clock);
        #1;
        reg_we = 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] ch, input logic [5:0] idx,
                            output logic [31:0] data);
        reg_raddr = {ch, idx};
        @(posedge clock);
        #1;
        data = reg_rdata;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_LIMIT) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!done) begin
            $display("Run did not finish: no done pulse within %0d cycles", DONE_LIMIT);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Test steps
    //////////////////////////////////////////////////

    task automatic set_row(input int i, input opcode_e op, input logic [31:0] base,
                           input logic [31:0] b, input logic [1:0] nch, input string name);
        rows[i].op   = op;
        rows[i].base = base;
        rows[i].b    = b;
        rows[i].nch  = nch;
        names[i]     = name;
    endtask

    task automatic fill_table();
        set_row(0, op_add, 32'h0000_0010, 32'h0000_0005, 2'd3, "add_4ch");
        set_row(1, op_sub, 32'h0000_0003, 32'h0000_0008, 2'd3, "sub_wrap");
        set_row(2, op_mul, 32'h1234_5678, 32'h0000_9abc, 2'd1, "mul_2ch");
        set_row(3, op_and, 32'hf0f0_f0f3, 32'h0ff0_0ff0, 2'd0, "and_1ch");
        set_row(4, op_or,  32'h0000_0f00, 32'h1234_0000, 2'd2, "or_3ch");
        set_row(5, op_xor, 32'haaaa_5555, 32'hffff_0000, 2'd3, "xor_4ch");
        // Only the low five bits of b count as shift amount
        set_row(6, op_shl, 32'h0000_0001, 32'h0000_0024, 2'd3, "shl_mask");
        set_row(7, op_nop, 32'h0000_0007, 32'h0000_0009, 2'd2, "nop_keeps");
        set_row(8, op_add, $urandom, $urandom, 2'($urandom), "rand_add");
        set_row(9, op_mul, $urandom, $urandom, 2'($urandom), "rand_mul");
        set_row(10, op_shl, $urandom, $urandom, 2'($urandom), "rand_shl");
    endtask

    task automatic check_reset();
        logic [31:0] got;
        logic [5:0]  idx;
        int          errs_before;
        errs_before = errors;
        compare("busy", 32'd0, 32'(busy));
        compare("done", 32'd0, 32'(done));
        for (int c = 0; c < MAX_CHANNELS; c++) begin
            for (int k = 0; k < 4; k++) begin
                idx = 6'(k * 21);
                read_reg(2'(c), idx, got);
                compare($sformatf("ch%0d r%0d", c, idx), 32'd0, got);
            end
        end
        report_test("reset_state", errs_before);
    endtask

    task automatic run_row(input int i);
        row_t        r;
        logic [31:0] got;
        logic [31:0] a_val;
        logic [31:0] exp_r2;
        logic [31:0] exp_r3;
        int          errs_before;
        errs_before = errors;
        r = rows[i];
        load_program(r.op, r.b);
        for (int c = 0; c < MAX_CHANNELS; c++) begin
            write_reg(2'(c), 6'd1, r.base + 32'(c));
            write_reg(2'(c), 6'd2, R2_MARK + 32'(c));
            write_reg(2'(c), 6'd3, R3_MARK + 32'(c));
        end
        write_reg(2'd0, 6'd5, BUSY_MARK + 32'(i));

        // Start, then try a host write that must be ignored
        run        = 1'b1;
        n_channels = r.nch;
        @(posedge clock);
        #1;
        run = 1'b0;
        compare("busy", 32'd1, 32'(busy));
        write_reg(2'd0, 6'd5, BLOCKED);
        wait_done();
        compare("busy", 32'd0, 32'(busy));

        for (int c = 0; c < MAX_CHANNELS; c++) begin
            a_val = r.base + 32'(c);
            if (c <= int'(r.nch)) begin
                exp_r2 = r.b;
                exp_r3 = (r.op == op_nop) ? R3_MARK + 32'(c)
                                          : expected_result(r.op, a_val, r.b);
            end else begin
                exp_r2 = R2_MARK + 32'(c);
                exp_r3 = R3_MARK + 32'(c);
            end
            read_reg(2'(c), 6'd1, got);
            compare($sformatf("ch%0d r1", c), a_val, got);
            read_reg(2'(c), 6'd2, got);
            compare($sformatf("ch%0d r2", c), exp_r2, got);
            read_reg(2'(c), 6'd3, got);
            compare($sformatf("ch%0d r3", c), exp_r3, got);
        end
        read_reg(2'd0, 6'd5, got);
        compare("ch0 r5", BUSY_MARK + 32'(i), got);
        compare("done_count", 32'(i + 1), 32'(done_count));
        report_test(names[i], errs_before);
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        reg_we     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        reg_raddr  = '0;
        run        = 1'b0;
        n_channels = '0;
        fill_table();
        @(posedge rst_n);
        @(posedge clock);
        #1;
        check_reset();
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== dv/clock_gen.sv ====
// Testbench clock source with a power-on reset held low for a few cycles
module clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Release lands just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== hdl/core_top.sv ====
// Multichannel processing core top level joining the pipeline blocks to the host ports
module core_top import core_pkg::*; #(
    parameter int PROG_DEPTH = 64
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    input  logic [DATA_WIDTH-1:0]         prog_data,
    input  logic                          reg_we,
    input  logic [ADDR_BITS-1:0]          reg_addr,
    input  logic [DATA_WIDTH-1:0]         reg_wdata,
    input  logic [ADDR_BITS-1:0]          reg_raddr,
    output logic [DATA_WIDTH-1:0]         reg_rdata,
    input  logic                          run,
    input  logic [CH_BITS-1:0]            n_channels,
    output logic                          busy,
    output logic                          done
);

    logic [$clog2(PROG_DEPTH)-1:0] pc;
    logic [2*DATA_WIDTH-1:0]       instr_pair;
    logic                          issue_en;
    logic [CH_BITS-1:0]            channel;
    logic                          stop_seen;
    issue_t                        issue;
    issue_t                        exec_issue;
    logic [DATA_WIDTH-1:0]         operand_a;
    logic [DATA_WIDTH-1:0]         operand_b;
    result_t                       wb;

    //////////////////////////////////////////////////
    // Fetch and sequencing
    //////////////////////////////////////////////////

    instr_store #(.PROG_DEPTH(PROG_DEPTH)) store_i (
        .clock, .prog_we, .prog_addr, .prog_data,
        .pc, .instr_pair
    );

    control_unit #(.PROG_DEPTH(PROG_DEPTH)) ctrl_i (
        .clock, .rst_n, .run, .n_channels, .stop_seen, .instr_pair,
        .pc, .issue_en, .channel, .busy, .done
    );

    //////////////////////////////////////////////////
    // Decode, operand read, execute
    //////////////////////////////////////////////////

    decoder dec_i (
        .clock, .rst_n, .issue_en, .channel, .instr_pair,
        .stop_seen, .issue
    );

    register_file regs_i (
        .clock, .rst_n, .busy, .issue, .wb,
        .reg_we, .reg_addr, .reg_wdata, .reg_raddr, .reg_rdata,
        .exec_issue, .operand_a, .operand_b
    );

    exec_unit exec_i (
        .clock, .rst_n, .exec_issue, .operand_a, .operand_b, .wb
    );

endmodule

// ==== hdl/exec_unit.sv ====
// Single-stage integer ALU producing the registered writeback
module exec_unit import core_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  issue_t                exec_issue,
    input  logic [DATA_WIDTH-1:0] operand_a,
    input  logic [DATA_WIDTH-1:0] operand_b,
    output result_t               wb
);

    logic [DATA_WIDTH-1:0] alu_out;
    logic                  writes;

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    always_comb begin
        alu_out = '0;
        writes  = 1'b1;
        case (exec_issue.op)
            op_add: alu_out = operand_a + operand_b;
            op_sub: alu_out = operand_a - operand_b;
            // Low half of the product only
            op_mul: alu_out = operand_a * operand_b;
            op_and: alu_out = operand_a & operand_b;
            op_or:  alu_out = operand_a | operand_b;
            op_xor: alu_out = operand_a ^ operand_b;
            op_shl: alu_out = operand_a << operand_b[4:0];
            op_ldc: alu_out = exec_issue.imm;
            default: begin
                // nop and unknown codes leave the registers alone
                writes = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= exec_issue.valid && writes;
            wb.addr  <= exec_issue.dest_addr;
            wb.data  <= alu_out;
        end
    end

endmodule

// ==== hdl/register_file.sv ====
// Channel-banked register file with operand reads, writeback and host access
module register_file import core_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  busy,
    input  issue_t                issue,
    input  result_t               wb,
    input  logic                  reg_we,
    input  logic [ADDR_BITS-1:0]  reg_addr,
    input  logic [DATA_WIDTH-1:0] reg_wdata,
    input  logic [ADDR_BITS-1:0]  reg_raddr,
    output logic [DATA_WIDTH-1:0] reg_rdata,
    output issue_t                exec_issue,
    output logic [DATA_WIDTH-1:0] operand_a,
    output logic [DATA_WIDTH-1:0] operand_b
);

    localparam int REG_COUNT = MAX_CHANNELS * (1 << REG_BITS);

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];
    logic                  host_wr;

    // Host writes only land while the core is idle
    assign host_wr = reg_we && !busy;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (host_wr) begin
                regs[reg_addr] <= reg_wdata;
            end
            if (wb.valid) begin
                regs[wb.addr] <= wb.data;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Operands come out together with the delayed slot
    always_ff @(posedge clock) begin
        operand_a <= regs[issue.a_addr];
        operand_b <= regs[issue.b_addr];
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            exec_issue <= '0;
        end else begin
            exec_issue <= issue;
        end
    end

    // Host read, one cycle latency
    always_ff @(posedge clock) begin
        reg_rdata <= regs[reg_raddr];
    end

endmodule

// ==== hdl/decoder.sv ====
// Instruction decoder turning the fetched pair into a registered issue slot
module decoder import core_pkg::*; (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    issue_en,
    input  logic [CH_BITS-1:0]      channel,
    input  logic [2*DATA_WIDTH-1:0] instr_pair,
    output logic                    stop_seen,
    output issue_t                  issue
);

    logic [DATA_WIDTH-1:0] word0;
    logic [DATA_WIDTH-1:0] word1;
    opcode_e               op;
    logic [REG_BITS-1:0]   dest;
    logic [REG_BITS-1:0]   src_a;
    logic [REG_BITS-1:0]   src_b;
    issue_t                slot;

    //////////////////////////////////////////////////
    // Field extraction
    //////////////////////////////////////////////////

    assign word0 = instr_pair[DATA_WIDTH-1:0];
    assign word1 = instr_pair[2*DATA_WIDTH-1:DATA_WIDTH];

    assign op    = opcode_e'(word0[OP_LSB +: OPCODE_BITS]);
    assign dest  = word0[DEST_LSB +: REG_BITS];
    assign src_a = word0[SRC_A_LSB +: REG_BITS];
    assign src_b = word0[SRC_B_LSB +: REG_BITS];

    // Seen by the control unit in the same cycle
    assign stop_seen = (op == op_stop);

    //////////////////////////////////////////////////
    // Issue slot
    //////////////////////////////////////////////////

    always_comb begin
        slot.valid     = issue_en && (op != op_stop);
        slot.op        = op;
        // Channel forms the upper address bits
        slot.dest_addr = {channel, dest};
        slot.a_addr    = {channel, src_a};
        slot.b_addr    = {channel, src_b};
        slot.imm       = (op == op_ldc) ? word1 : '0;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            issue <= '0;
        end else begin
            issue <= slot;
        end
    end

endmodule

// ==== hdl/control_unit.sv ====
// Run sequencer stepping the program counter and issuing each instruction per channel
module control_unit import core_pkg::*; #(
    parameter int PROG_DEPTH = 64
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic [CH_BITS-1:0]            n_channels,
    input  logic                          stop_seen,
    input  logic [2*DATA_WIDTH-1:0]       instr_pair,
    output logic [$clog2(PROG_DEPTH)-1:0] pc,
    output logic                          issue_en,
    output logic [CH_BITS-1:0]            channel,
    output logic                          busy,
    output logic                          done
);

    localparam int DRAIN_BITS = $clog2(PIPE_DEPTH + 1);

    ctrl_state_e           state;
    logic [CH_BITS-1:0]    last_ch;
    logic [DRAIN_BITS-1:0] drain_cnt;
    opcode_e               cur_op;

    assign cur_op   = opcode_e'(instr_pair[OP_LSB +: OPCODE_BITS]);
    assign issue_en = (state == st_issue) && !stop_seen;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            pc        <= '0;
            channel   <= '0;
            last_ch   <= '0;
            drain_cnt <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (run) begin
                        pc      <= '0;
                        channel <= '0;
                        last_ch <= n_channels;
                        busy    <= 1'b1;
                        state   <= st_fetch;
                    end
                end
                // Store registers the pair at pc during this cycle
                st_fetch: begin
                    state <= st_issue;
                end
                st_issue: begin
                    if (stop_seen) begin
                        drain_cnt <= '0;
                        state     <= st_drain;
                    end else if (channel == last_ch) begin
                        channel <= '0;
                        pc      <= (cur_op == op_ldc) ? pc + 2'd2 : pc + 1'b1;
                        state   <= st_fetch;
                    end else begin
                        channel <= channel + 1'b1;
                    end
                end
                // Wait for the last slots to write back
                st_drain: begin
                    if (drain_cnt == DRAIN_BITS'(PIPE_DEPTH - 1)) begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= st_idle;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== hdl/instr_store.sv ====
// Program memory loaded by the host, fetching the word pair at pc in one access
module instr_store #(
    parameter int PROG_DEPTH = 64
) (
    input  logic                          clock,
    input  logic                          prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    input  logic [31:0]                   prog_data,
    input  logic [$clog2(PROG_DEPTH)-1:0] pc,
    output logic [63:0]                   instr_pair
);

    localparam int PC_BITS = $clog2(PROG_DEPTH);

    logic [31:0]        mem [PROG_DEPTH];
    logic [PC_BITS-1:0] pc_next;

    // Second word wraps to the start at the end of the store
    assign pc_next = (pc == PC_BITS'(PROG_DEPTH - 1)) ? '0 : pc + 1'b1;

    always_ff @(posedge clock) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Low half is the word at pc, high half the word after it
    always_ff @(posedge clock) begin
        instr_pair <= {mem[pc_next], mem[pc]};
    end

endmodule

// ==== hdl/core_pkg.sv ====
// Shared widths, instruction layout, enums and pipeline structs for the processing core
package core_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int DATA_WIDTH   = 32;
    localparam int REG_BITS     = 6;
    localparam int CH_BITS      = 2;
    localparam int MAX_CHANNELS = 1 << CH_BITS;
    localparam int ADDR_BITS    = REG_BITS + CH_BITS;

    // Cycles from decoder issue to register writeback
    localparam int PIPE_DEPTH = 3;

    // Instruction word layout, opcode at the top
    localparam int OPCODE_BITS = 5;
    localparam int OP_LSB      = 27;
    localparam int DEST_LSB    = 21;
    localparam int SRC_A_LSB   = 15;
    localparam int SRC_B_LSB   = 9;

    //////////////////////////////////////////////////
    // Enums and structs
    //////////////////////////////////////////////////

    typedef enum logic [OPCODE_BITS-1:0] {
        op_nop, op_add, op_sub, op_mul, op_and,
        op_or, op_xor, op_shl, op_ldc, op_stop
    } opcode_e;

    typedef enum logic [1:0] {
        st_idle, st_fetch, st_issue, st_drain
    } ctrl_state_e;

    // One decoded slot, addresses already carry the channel
    typedef struct packed {
        logic                  valid;
        opcode_e               op;
        logic [ADDR_BITS-1:0]  dest_addr;
        logic [ADDR_BITS-1:0]  a_addr;
        logic [ADDR_BITS-1:0]  b_addr;
        logic [DATA_WIDTH-1:0] imm;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_BITS-1:0]  addr;
        logic [DATA_WIDTH-1:0] data;
    } result_t;

endpackage
